// ==== flist.f ====
source/coreTypes.sv
source/divTypes.sv
source/divUopIf.sv
source/resultIf.sv
source/divIssueQueue.sv
source/nonRestoringDivider.sv
source/divCluster.sv
tb/divClusterTb.sv

// ==== source/coreTypes.sv ====
`default_nettype none

package coreTypes;

    // sequence numbers wrap, so age is decided by the signed distance
    localparam int sqnWidth = 7;

    typedef logic [sqnWidth-1:0] SqN;

    // physical destination tag
    typedef logic [5:0] Tag;

    // architectural destination register
    typedef logic [4:0] RegName;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // age rule shared by the back end
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // true when a is strictly younger than b
    function automatic logic isYounger(input SqN a, input SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

`default_nettype wire

// ==== source/divCluster.sv ====
`timescale 1ns/1ps
`default_nettype none

module divCluster #(
    parameter int queueDepth = 4
) (
    input wire clk,
    input wire rst,

    // dispatch
    input wire dispValid,
    input wire divTypes::DivOp dispOp,
    input wire [31:0] dispSrcA,
    input wire [31:0] dispSrcB,
    input wire coreTypes::SqN dispSqN,
    input wire coreTypes::Tag dispTagDst,
    input wire coreTypes::RegName dispNmDst,
    output logic dispFull,

    input wire branchTaken,
    input wire coreTypes::SqN branchSqN,

    // writeback, no back-pressure
    output logic resValid,
    output logic [31:0] resData,
    output coreTypes::SqN resSqN,
    output coreTypes::Tag resTagDst,
    output coreTypes::RegName resNmDst,
    output divTypes::ResFlags resFlags
);

    logic divBusy;

    divUopIf uopBus ();
    resultIf resBus ();

    divIssueQueue #(
        .queueDepth(queueDepth)
    ) divIssueQueue_inst (
        .clk(clk),
        .rst(rst),
        .inValid(dispValid),
        .inOp(dispOp),
        .inSrcA(dispSrcA),
        .inSrcB(dispSrcB),
        .inSqN(dispSqN),
        .inTagDst(dispTagDst),
        .inNmDst(dispNmDst),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .busy(divBusy),
        .full(dispFull),
        .issue(uopBus.issue)
    );

    nonRestoringDivider nonRestoringDivider_inst (
        .clk(clk),
        .rst(rst),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .uop(uopBus.exec),
        .res(resBus.src),
        .busy(divBusy)
    );

    assign resValid = resBus.valid;
    assign resData = resBus.result;
    assign resSqN = resBus.sqN;
    assign resTagDst = resBus.tagDst;
    assign resNmDst = resBus.nmDst;
    assign resFlags = resBus.flags;

endmodule

`default_nettype wire

// ==== source/divIssueQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module divIssueQueue #(
    parameter int queueDepth = 4
) (
    input wire clk,
    input wire rst,

    input wire inValid,
    input wire divTypes::DivOp inOp,
    input wire [31:0] inSrcA,
    input wire [31:0] inSrcB,
    input wire coreTypes::SqN inSqN,
    input wire coreTypes::Tag inTagDst,
    input wire coreTypes::RegName inNmDst,

    input wire branchTaken,
    input wire coreTypes::SqN branchSqN,

    input wire busy,
    output logic full,

    divUopIf.issue issue
);

    localparam int ptrWidth = $clog2(queueDepth);
    localparam int countWidth = $clog2(queueDepth + 1);

    // entry storage, oldest at rdPtr
    divTypes::DivOp opQ [queueDepth];
    logic [31:0] srcAQ [queueDepth];
    logic [31:0] srcBQ [queueDepth];
    coreTypes::SqN sqNQ [queueDepth];
    coreTypes::Tag tagQ [queueDepth];
    coreTypes::RegName nmQ [queueDepth];

    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] wrBase;
    logic [countWidth-1:0] count;
    logic [countWidth-1:0] keep;
    logic doWrite;
    logic doIssue;

    // slot that lies offset entries after base, depth need not be a power of two
    function automatic logic [ptrWidth-1:0] slotAt(
        input logic [ptrWidth-1:0] base,
        input int offset
    );
        int sum;
        sum = int'(base) + offset;
        if (sum >= queueDepth) begin
            sum = sum - queueDepth;
        end
        return ptrWidth'(sum);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // branch flush
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // entries are in age order, so the first younger one cuts the queue
    always_comb begin
        keep = count;
        wrBase = wrPtr;
        if (branchTaken) begin
            for (int i = queueDepth - 1; i >= 0; i--) begin
                if (i < int'(count) &&
                        coreTypes::isYounger(sqNQ[slotAt(rdPtr, i)], branchSqN)) begin
                    keep = countWidth'(i);
                    wrBase = slotAt(rdPtr, i);
                end
            end
        end
    end

    assign full = (count == countWidth'(queueDepth));

    // a dispatch already younger than the branch is dropped
    assign doWrite = inValid && !full &&
        !(branchTaken && coreTypes::isYounger(inSqN, branchSqN));

    // head must survive the flush; one issue per free divider slot
    assign doIssue = (keep != '0) && !busy && !issue.valid;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            opQ[wrBase] <= inOp;
            srcAQ[wrBase] <= inSrcA;
            srcBQ[wrBase] <= inSrcB;
            sqNQ[wrBase] <= inSqN;
            tagQ[wrBase] <= inTagDst;
            nmQ[wrBase] <= inNmDst;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= doIssue;
            if (doIssue) begin
                rdPtr <= slotAt(rdPtr, 1);
            end
            wrPtr <= doWrite ? slotAt(wrBase, 1) : wrBase;
            count <= keep + countWidth'(doWrite) - countWidth'(doIssue);
        end
    end

    // issue payload
    always_ff @(posedge clk) begin
        if (doIssue) begin
            issue.op <= opQ[rdPtr];
            issue.srcA <= srcAQ[rdPtr];
            issue.srcB <= srcBQ[rdPtr];
            issue.sqN <= sqNQ[rdPtr];
            issue.tagDst <= tagQ[rdPtr];
            issue.nmDst <= nmQ[rdPtr];
        end
    end

endmodule

`default_nettype wire

// ==== source/divTypes.sv ====
`default_nettype none

package divTypes;

    // quotient and remainder, signed and unsigned
    typedef enum logic [1:0] {
        divS,
        divU,
        remS,
        remU
    } DivOp;

    // flagsDivZero marks a zero divisor
    typedef enum logic [1:0] {
        flagsNone,
        flagsDivZero
    } ResFlags;

    // one quotient bit per iteration
    localparam int iterations = 32;

    // counter must also hold the final value
    localparam int cntWidth = $clog2(iterations) + 1;
    localparam logic [cntWidth-1:0] finalCount = cntWidth'(iterations);

endpackage

`default_nettype wire

// ==== source/divUopIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// one divide micro-op, queue to divider
interface divUopIf;

    logic valid;
    divTypes::DivOp op;
    logic [31:0] srcA;
    logic [31:0] srcB;
    coreTypes::SqN sqN;
    coreTypes::Tag tagDst;
    coreTypes::RegName nmDst;

    modport issue (
        output valid, op, srcA, srcB, sqN, tagDst, nmDst
    );

    modport exec (
        input valid, op, srcA, srcB, sqN, tagDst, nmDst
    );

endinterface

`default_nettype wire

// ==== source/nonRestoringDivider.sv ====
`timescale 1ns/1ps
`default_nettype none

module nonRestoringDivider (
    input wire clk,
    input wire rst,

    input wire branchTaken,
    input wire coreTypes::SqN branchSqN,

    divUopIf.exec uop,
    resultIf.src res,

    output logic busy
);

    localparam int w = divTypes::iterations;

    logic running;
    logic [divTypes::cntWidth-1:0] cnt;

    // partial remainder carries two extra bits for the shifted sign
    logic [w+1:0] rem;
    logic [w-1:0] dvd;
    logic [w-1:0] quo;
    logic [w-1:0] dsr;
    logic [w-1:0] dividend;
    logic invert;
    logic isDivZero;
    logic isOverflow;

    divTypes::DivOp op;
    coreTypes::SqN sqN;
    coreTypes::Tag tagDst;
    coreTypes::RegName nmDst;

    logic signedIn;
    logic [w-1:0] absA;
    logic [w-1:0] absB;
    logic acceptNow;
    logic killRun;
    logic [w+1:0] shifted;
    logic [w+1:0] stepRem;
    logic [w-1:0] quoFix;
    logic [w-1:0] remFix;
    logic isRem;
    logic [w-1:0] finalResult;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand preparation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign signedIn = (uop.op == divTypes::divS) || (uop.op == divTypes::remS);
    assign absA = (signedIn && uop.srcA[w-1]) ? -uop.srcA : uop.srcA;
    assign absB = (signedIn && uop.srcB[w-1]) ? -uop.srcB : uop.srcB;

    // incoming op killed by a branch sampled at the same edge
    assign acceptNow = uop.valid &&
        !(branchTaken && coreTypes::isYounger(uop.sqN, branchSqN));
    assign killRun = running && branchTaken && coreTypes::isYounger(sqN, branchSqN);

    // free to take a new op at the result edge
    assign busy = running && (cnt < divTypes::finalCount - 1'b1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // iteration step
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign shifted = {rem[w:0], dvd[w-1]};
    assign stepRem = rem[w+1] ? (shifted + {2'b0, dsr}) : (shifted - {2'b0, dsr});

    // digits are +1/-1, convert then correct a negative remainder
    assign quoFix = quo - ~quo - {{(w-1){1'b0}}, rem[w+1]};
    assign remFix = rem[w+1] ? (rem[w-1:0] + dsr) : rem[w-1:0];

    assign isRem = (op == divTypes::remS) || (op == divTypes::remU);

    always_comb begin
        if (isDivZero) begin
            finalResult = isRem ? dividend : '1;
        end else if (isOverflow) begin
            finalResult = isRem ? '0 : dividend;
        end else if (isRem) begin
            finalResult = invert ? -remFix : remFix;
        end else begin
            finalResult = invert ? -quoFix : quoFix;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            running <= 1'b0;
            cnt <= '0;
            res.valid <= 1'b0;
        end else begin
            res.valid <= 1'b0;

            if (killRun) begin
                running <= 1'b0;
            end else if (running) begin
                if (cnt == divTypes::finalCount) begin
                    running <= 1'b0;
                    res.valid <= 1'b1;
                    res.result <= finalResult;
                    res.sqN <= sqN;
                    res.tagDst <= tagDst;
                    res.nmDst <= nmDst;
                    res.flags <= isDivZero ? divTypes::flagsDivZero : divTypes::flagsNone;
                end else begin
                    rem <= stepRem;
                    dvd <= dvd << 1;
                    quo <= {quo[w-2:0], ~rem[w+1]};
                    cnt <= cnt + 1'b1;
                end
            end

            // may overlap the result edge of the previous op
            if (acceptNow) begin
                running <= 1'b1;
                cnt <= '0;
                rem <= '0;
                dvd <= absA;
                dsr <= absB;
                dividend <= uop.srcA;
                op <= uop.op;
                sqN <= uop.sqN;
                tagDst <= uop.tagDst;
                nmDst <= uop.nmDst;
                isDivZero <= (uop.srcB == '0);
                isOverflow <= signedIn && (uop.srcA == {1'b1, {(w-1){1'b0}}}) &&
                    (uop.srcB == '1);
                case (uop.op)
                    divTypes::divS: invert <= uop.srcA[w-1] ^ uop.srcB[w-1];
                    divTypes::remS: invert <= uop.srcA[w-1];
                    default: invert <= 1'b0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/resultIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// finished result, valid is a single-cycle strobe
interface resultIf;

    logic valid;
    logic [31:0] result;
    coreTypes::SqN sqN;
    coreTypes::Tag tagDst;
    coreTypes::RegName nmDst;
    divTypes::ResFlags flags;

    modport src (
        output valid, result, sqN, tagDst, nmDst, flags
    );

    modport sink (
        input valid, result, sqN, tagDst, nmDst, flags
    );

endinterface

`default_nettype wire

// ==== tb/divClusterTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module divClusterTb;

    localparam int fullTimeout = 200;
    localparam int drainTimeout = 400;
    localparam int quietCycles = 40;
    localparam int idleLatency = 35;

    logic clk;
    logic rst;
    logic dispValid;
    divTypes::DivOp dispOp;
    logic [31:0] dispSrcA;
    logic [31:0] dispSrcB;
    coreTypes::SqN dispSqN;
    coreTypes::Tag dispTagDst;
    coreTypes::RegName dispNmDst;
    logic dispFull;
    logic branchTaken;
    coreTypes::SqN branchSqN;
    logic resValid;
    logic [31:0] resData;
    coreTypes::SqN resSqN;
    coreTypes::Tag resTagDst;
    coreTypes::RegName resNmDst;
    divTypes::ResFlags resFlags;

    // outstanding results, oldest first
    coreTypes::SqN pendSqN [$];
    logic [31:0] pendData [$];
    bit pendDivZero [$];
    bit pendIdle [$];
    int pendEdge [$];

    int edgeCount;
    int errors;
    int errorsAtStart;
    int checks;
    int testsDone;
    int testResults;
    bit sawFull;
    bit aborted;

    divCluster #(
        .queueDepth(4)
    ) divCluster_inst (
        .clk(clk),
        .rst(rst),
        .dispValid(dispValid),
        .dispOp(dispOp),
        .dispSrcA(dispSrcA),
        .dispSrcB(dispSrcB),
        .dispSqN(dispSqN),
        .dispTagDst(dispTagDst),
        .dispNmDst(dispNmDst),
        .dispFull(dispFull),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .resValid(resValid),
        .resData(resData),
        .resSqN(resSqN),
        .resTagDst(resTagDst),
        .resNmDst(resNmDst),
        .resFlags(resFlags)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // positive wrapped distance means a came later
    function automatic bit youngerThan(input coreTypes::SqN a, input coreTypes::SqN b);
        coreTypes::SqN d;
        d = a - b;
        return (d != '0) && !d[$bits(d)-1];
    endfunction

    function automatic coreTypes::Tag tagFor(input coreTypes::SqN s);
        return s[5:0] ^ 6'h2a;
    endfunction

    function automatic coreTypes::RegName nameFor(input coreTypes::SqN s);
        return s[4:0] + 5'd3;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one cycle, result checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic nextCycle();
        int lat;
        coreTypes::SqN sqTmp;
        logic [31:0] dataTmp;
        bit dzTmp;
        bit idleTmp;
        int edgeTmp;
        @(negedge clk);
        edgeCount++;
        if (dispFull) begin
            sawFull = 1'b1;
        end
        if (resValid) begin
            checks++;
            testResults++;
            if (pendSqN.size() == 0) begin
                errors++;
                $display("[FAIL] t=%0t result sqN %0d with nothing outstanding", $time, resSqN);
            end else begin
                sqTmp = pendSqN.pop_front();
                dataTmp = pendData.pop_front();
                dzTmp = pendDivZero.pop_front();
                idleTmp = pendIdle.pop_front();
                edgeTmp = pendEdge.pop_front();
                lat = edgeCount - edgeTmp;
                if (resSqN !== sqTmp) begin
                    errors++;
                    $display("[FAIL] t=%0t sqN %0d, expected %0d", $time, resSqN, sqTmp);
                end else if (resData !== dataTmp) begin
                    errors++;
                    $display("[FAIL] t=%0t sqN %0d data %h, expected %h",
                        $time, sqTmp, resData, dataTmp);
                end
                if (resTagDst !== tagFor(sqTmp) || resNmDst !== nameFor(sqTmp)) begin
                    errors++;
                    $display("[FAIL] t=%0t sqN %0d tag %0d name %0d do not match",
                        $time, sqTmp, resTagDst, resNmDst);
                end
                if (resFlags !== (dzTmp ? divTypes::flagsDivZero : divTypes::flagsNone)) begin
                    errors++;
                    $display("[FAIL] t=%0t sqN %0d flags %0d wrong", $time, sqTmp, resFlags);
                end
                if (idleTmp && lat != idleLatency) begin
                    errors++;
                    $display("[FAIL] t=%0t sqN %0d latency %0d, expected %0d",
                        $time, sqTmp, lat, idleLatency);
                end
            end
        end
    endtask

    task automatic dispatchOp(input int op, input logic [31:0] a, input logic [31:0] b,
            input int sqN, input logic [31:0] expected);
        int waited;
        coreTypes::SqN s;
        waited = 0;
        s = coreTypes::SqN'(sqN);
        while (dispFull && !aborted) begin
            if (waited >= fullTimeout) begin
                $display("timeout: dispFull stayed high before dispatching sqN %0d", sqN);
                aborted = 1'b1;
            end else begin
                nextCycle();
                waited++;
            end
        end
        if (!aborted) begin
            dispValid = 1'b1;
            dispOp = divTypes::DivOp'(op[1:0]);
            dispSrcA = a;
            dispSrcB = b;
            dispSqN = s;
            dispTagDst = tagFor(s);
            dispNmDst = nameFor(s);
            pendIdle.push_back(pendSqN.size() == 0);
            pendSqN.push_back(s);
            pendData.push_back(expected);
            pendDivZero.push_back(b == 32'h0);
            pendEdge.push_back(edgeCount + 1);
            nextCycle();
            dispValid = 1'b0;
        end
    endtask

    task automatic branchAt(input int sqN);
        coreTypes::SqN s;
        coreTypes::SqN sqTmp;
        logic [31:0] dataTmp;
        bit bitTmp;
        int edgeTmp;
        s = coreTypes::SqN'(sqN);
        branchTaken = 1'b1;
        branchSqN = s;
        // list is in age order, so killed ones sit at the back
        while (pendSqN.size() > 0 && youngerThan(pendSqN[$], s)) begin
            sqTmp = pendSqN.pop_back();
            dataTmp = pendData.pop_back();
            bitTmp = pendDivZero.pop_back();
            bitTmp = pendIdle.pop_back();
            edgeTmp = pendEdge.pop_back();
        end
        nextCycle();
        branchTaken = 1'b0;
    endtask

    task automatic finishTest(input int testId, input int expectFull);
        int waited;
        waited = 0;
        while (pendSqN.size() > 0 && !aborted) begin
            if (waited >= drainTimeout) begin
                $display("timeout: %0d results of test %0d never arrived",
                    pendSqN.size(), testId);
                aborted = 1'b1;
            end else begin
                nextCycle();
                waited++;
            end
        end
        // stray results of killed micro-ops would land here
        for (int i = 0; i < quietCycles && !aborted; i++) begin
            nextCycle();
        end
        if (!aborted) begin
            checks++;
            if (sawFull != (expectFull != 0)) begin
                errors++;
                $display("[FAIL] t=%0t test %0d dispFull seen %0d, expected %0d",
                    $time, testId, sawFull, expectFull);
            end
            $display("test %0d finished: %0d results, %0d errors",
                testId, testResults, errors - errorsAtStart);
            testsDone++;
        end
        testResults = 0;
        sawFull = 1'b0;
        errorsAtStart = errors;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command loop
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int fd;
        int code;
        int ch;
        int testId;
        int op;
        int sqN;
        int count;
        int expectFull;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        logic [7:0] cmd;
        rst = 1'b0;
        dispValid = 1'b0;
        dispOp = divTypes::divS;
        dispSrcA = '0;
        dispSrcB = '0;
        dispSqN = '0;
        dispTagDst = '0;
        dispNmDst = '0;
        branchTaken = 1'b0;
        branchSqN = '0;
        edgeCount = 0;
        errors = 0;
        errorsAtStart = 0;
        checks = 0;
        testsDone = 0;
        testResults = 0;
        sawFull = 1'b0;
        aborted = 1'b0;
        fd = $fopen("tb/divStim.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/divStim.txt");
            aborted = 1'b1;
        end
        repeat (2) @(negedge clk);
        rst = 1'b1;
        while (!aborted) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) begin
                break;
            end
            case (cmd)
                "#": begin
                    ch = 0;
                    while (ch != "\n" && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
                "D": begin
                    code = $fscanf(fd, "%d %d %h %h %d %h", testId, op, a, b, sqN, expected);
                    if (code == 6) begin
                        dispatchOp(op, a, b, sqN, expected);
                    end else begin
                        $display("malformed dispatch line in stimulus file");
                        aborted = 1'b1;
                    end
                end
                "B": begin
                    code = $fscanf(fd, "%d", sqN);
                    branchAt(sqN);
                end
                "W": begin
                    code = $fscanf(fd, "%d", count);
                    repeat (count) nextCycle();
                end
                "E": begin
                    code = $fscanf(fd, "%d %d", testId, expectFull);
                    finishTest(testId, expectFull);
                end
                default: begin
                    $display("unknown command '%c' in stimulus file", cmd);
                    aborted = 1'b1;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("tests %0d, checks %0d, errors %0d", testsDone, checks, errors);
        if (errors == 0 && !aborted && testsDone > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/divStim.txt ====
# D test op(0 divS, 1 divU, 2 remS, 3 remU) srcA(hex) srcB(hex) sqN expected(hex)
# B branchSqN / W cycles / E test expectFull(1 when dispFull must rise)
D 1 0 00000007 fffffffe 1 fffffffd
D 1 0 ffffff9c fffffff9 2 0000000e
D 1 1 fffffff9 00000002 3 7ffffffc
D 1 2 fffffff9 00000002 4 ffffffff
D 1 2 00000007 fffffffe 5 00000001
D 1 3 fffffff9 0000000a 6 00000009
E 1 1
D 2 0 00000005 00000000 7 ffffffff
D 2 3 12345678 00000000 8 12345678
D 2 0 80000000 ffffffff 9 80000000
D 2 2 80000000 ffffffff 10 00000000
E 2 0
D 3 1 00000064 00000003 11 00000021
D 3 3 00000064 00000003 12 00000001
D 3 0 fffffff7 00000004 13 fffffffe
D 3 2 fffffff7 00000004 14 ffffffff
D 3 1 ffffffff 00000001 15 ffffffff
D 3 3 12345678 00000064 16 00000060
E 3 1
D 4 1 00000032 00000005 17 0000000a
D 4 3 00000032 00000007 18 00000001
D 4 0 ffffffce 00000005 19 fffffff6
D 4 1 00000009 00000003 20 00000003
B 18
E 4 0
D 5 0 000003e8 fffffffd 21 fffffeb3
W 10
B 20
D 5 3 000003e8 00000003 22 00000001
E 5 0
D 6 1 0000ffff 00000010 23 00000fff
E 6 0
